/* design/cpu_defs_pkg.sv */
package cpu_defs_pkg;

	// general register file
	localparam int DATA_WIDTH     = 32;
	localparam int REG_NUM        = 32;
	localparam int REG_ADDR_WIDTH = $clog2(REG_NUM);

	// cycles MULTU stays in execute
	localparam int MUL_CYCLES     = 4;
	localparam int MUL_CNT_WIDTH  = $clog2(MUL_CYCLES);

	// one data word
	typedef logic [DATA_WIDTH-1:0] uint32_t;

	// HI/LO pair, HI in the upper word
	typedef logic [2*DATA_WIDTH-1:0] uint64_t;

	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

endpackage

/* design/isa_pkg.sv */
package isa_pkg;

	localparam int INSTR_WIDTH = 32;

	typedef logic [INSTR_WIDTH-1:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// field positions inside the instruction word
	localparam int OPC_LSB   = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB   = 0;
	localparam int IMM_WIDTH = 16;

	// primary opcodes
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_LUI     = 6'h0f;

	// SPECIAL function codes
	localparam funct_t FN_MFHI  = 6'h10;
	localparam funct_t FN_MFLO  = 6'h12;
	localparam funct_t FN_MULTU = 6'h19;
	localparam funct_t FN_ADDU  = 6'h21;
	localparam funct_t FN_SUBU  = 6'h23;
	localparam funct_t FN_AND   = 6'h24;
	localparam funct_t FN_OR    = 6'h25;
	localparam funct_t FN_XOR   = 6'h26;
	localparam funct_t FN_SLT   = 6'h2a;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI,
		ALU_MFHI,
		ALU_MFLO,
		ALU_MULTU
	} alu_op_t;

endpackage

/* design/regfile.sv */
`timescale 1ns/10ps

module regfile(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    we,
	input  cpu_defs_pkg::reg_addr_t waddr,
	input  cpu_defs_pkg::uint32_t   wdata,
	input  cpu_defs_pkg::reg_addr_t rs_addr,
	input  cpu_defs_pkg::reg_addr_t rt_addr,
	output cpu_defs_pkg::uint32_t   rs_data,
	output cpu_defs_pkg::uint32_t   rt_data
);
	import cpu_defs_pkg::*;

	uint32_t regs [REG_NUM];

	// register 0 never takes a write, so it stays at its reset value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// no write bypass here
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* design/decode.sv */
`timescale 1ns/10ps

module decode(
	input  isa_pkg::instr_t         instr,
	input  logic                    in_valid,
	output cpu_defs_pkg::reg_addr_t rs_addr,
	output cpu_defs_pkg::reg_addr_t rt_addr,
	input  cpu_defs_pkg::uint32_t   rs_data,
	input  cpu_defs_pkg::uint32_t   rt_data,
	input  cpu_defs_pkg::reg_addr_t ex_rd,
	input  cpu_defs_pkg::uint32_t   ex_result,
	input  cpu_defs_pkg::reg_addr_t wb_rd,
	input  cpu_defs_pkg::uint32_t   wb_data,
	output isa_pkg::alu_op_t        op,
	output cpu_defs_pkg::uint32_t   opa,
	output cpu_defs_pkg::uint32_t   opb,
	output cpu_defs_pkg::reg_addr_t rd
);
	import cpu_defs_pkg::*;
	import isa_pkg::*;

	opcode_t              opcode;
	funct_t               funct;
	reg_addr_t            rd_field;
	logic [IMM_WIDTH-1:0] imm;
	uint32_t              rs_value;
	uint32_t              rt_value;
	uint32_t              imm_sext;
	uint32_t              imm_zext;
	uint32_t              imm_upper;

	// execute beats write-back, write-back beats the register file
	function automatic uint32_t forward(
		input reg_addr_t src,
		input uint32_t   rf_val,
		input reg_addr_t ex_dst,
		input uint32_t   ex_val,
		input reg_addr_t wb_dst,
		input uint32_t   wb_val
	);
		if (src == '0)
			return '0;
		else if (src == ex_dst)
			return ex_val;
		else if (src == wb_dst)
			return wb_val;
		return rf_val;
	endfunction

	assign opcode   = instr[OPC_LSB +: $bits(opcode_t)];
	assign funct    = instr[FUNCT_LSB +: $bits(funct_t)];
	assign rs_addr  = instr[RS_LSB +: $bits(reg_addr_t)];
	assign rt_addr  = instr[RT_LSB +: $bits(reg_addr_t)];
	assign rd_field = instr[RD_LSB +: $bits(reg_addr_t)];
	assign imm      = instr[IMM_LSB +: IMM_WIDTH];

	assign imm_sext  = {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
	assign imm_zext  = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};
	assign imm_upper = {imm, {(DATA_WIDTH-IMM_WIDTH){1'b0}}};

	assign rs_value = forward(rs_addr, rs_data, ex_rd, ex_result, wb_rd, wb_data);
	assign rt_value = forward(rt_addr, rt_data, ex_rd, ex_result, wb_rd, wb_data);

	always_comb begin
		op  = ALU_NOP;
		rd  = '0;
		opa = rs_value;
		opb = rt_value;
		// unknown encodings fall through as NOP with no destination
		if (in_valid) begin
			case (opcode)
				OP_SPECIAL: begin
					case (funct)
						FN_ADDU: begin
							op = ALU_ADD;
							rd = rd_field;
						end
						FN_SUBU: begin
							op = ALU_SUB;
							rd = rd_field;
						end
						FN_AND: begin
							op = ALU_AND;
							rd = rd_field;
						end
						FN_OR: begin
							op = ALU_OR;
							rd = rd_field;
						end
						FN_XOR: begin
							op = ALU_XOR;
							rd = rd_field;
						end
						FN_SLT: begin
							op = ALU_SLT;
							rd = rd_field;
						end
						FN_MFHI: begin
							op = ALU_MFHI;
							rd = rd_field;
						end
						FN_MFLO: begin
							op = ALU_MFLO;
							rd = rd_field;
						end
						// result goes to HI/LO only
						FN_MULTU: op = ALU_MULTU;
						default:  op = ALU_NOP;
					endcase
				end
				OP_ADDIU: begin
					op  = ALU_ADD;
					rd  = rt_addr;
					opb = imm_sext;
				end
				OP_ORI: begin
					op  = ALU_OR;
					rd  = rt_addr;
					opb = imm_zext;
				end
				OP_LUI: begin
					op  = ALU_LUI;
					rd  = rt_addr;
					opb = imm_upper;
				end
				default: op = ALU_NOP;
			endcase
		end
	end

endmodule

/* design/instr_exec.sv */
`timescale 1ns/10ps

module instr_exec(
	input  logic                  clk,
	input  logic                  rst,
	input  isa_pkg::alu_op_t      op,
	input  cpu_defs_pkg::uint32_t opa,
	input  cpu_defs_pkg::uint32_t opb,
	output cpu_defs_pkg::uint32_t result,
	output logic                  stall_req
);
	import cpu_defs_pkg::*;
	import isa_pkg::*;

	typedef enum logic [0:0] {
		MUL_IDLE,
		MUL_BUSY
	} mul_state_t;

	mul_state_t             mul_state;
	logic [MUL_CNT_WIDTH-1:0] mul_cnt;
	logic                   mul_done;
	uint64_t                hilo;
	uint64_t                product;

	assign product = uint64_t'(opa) * uint64_t'(opb);

	// first cycle is spent in idle, so done comes on the last busy count
	assign mul_done  = (mul_state == MUL_BUSY) && (mul_cnt == MUL_CNT_WIDTH'(MUL_CYCLES - 1));
	assign stall_req = (op == ALU_MULTU) && !mul_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			mul_state <= MUL_IDLE;
			mul_cnt   <= '0;
		end else begin
			case (mul_state)
				MUL_IDLE: begin
					if (op == ALU_MULTU) begin
						mul_state <= MUL_BUSY;
						mul_cnt   <= MUL_CNT_WIDTH'(1);
					end
				end
				MUL_BUSY: begin
					if (mul_done) begin
						mul_state <= MUL_IDLE;
						mul_cnt   <= '0;
					end else begin
						mul_cnt <= mul_cnt + 1'b1;
					end
				end
				default: mul_state <= MUL_IDLE;
			endcase
		end
	end

	// HI/LO updated at the edge that ends the multiply
	always_ff @(posedge clk) begin
		if (rst)
			hilo <= '0;
		else if (mul_done)
			hilo <= product;
	end

	always_comb begin
		case (op)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_AND:  result = opa & opb;
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			ALU_SLT:  result = uint32_t'($signed(opa) < $signed(opb));
			ALU_LUI:  result = opb;
			ALU_MFHI: result = hilo[DATA_WIDTH +: DATA_WIDTH];
			ALU_MFLO: result = hilo[0 +: DATA_WIDTH];
			default:  result = '0;
		endcase
	end

endmodule

/* design/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instr_valid,
	input  isa_pkg::instr_t         instr,
	output logic                    instr_ready,
	output logic                    wb_valid,
	output cpu_defs_pkg::reg_addr_t wb_rd,
	output cpu_defs_pkg::uint32_t   wb_data
);
	import cpu_defs_pkg::*;
	import isa_pkg::*;

	logic      accept;
	logic      stall_req;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	uint32_t   rs_data;
	uint32_t   rt_data;

	alu_op_t   dec_op;
	uint32_t   dec_opa;
	uint32_t   dec_opb;
	reg_addr_t dec_rd;

	alu_op_t   ex_op;
	uint32_t   ex_opa;
	uint32_t   ex_opb;
	reg_addr_t ex_rd;
	uint32_t   ex_result;

	assign instr_ready = ~stall_req;
	assign accept      = instr_valid & instr_ready;

	regfile i_regfile(
		.clk,
		.rst,
		.we      ( wb_valid ),
		.waddr   ( wb_rd    ),
		.wdata   ( wb_data  ),
		.rs_addr,
		.rt_addr,
		.rs_data,
		.rt_data
	);

	// a cycle without acceptance decodes to a bubble
	decode i_decode(
		.instr,
		.in_valid  ( accept    ),
		.rs_addr,
		.rt_addr,
		.rs_data,
		.rt_data,
		.ex_rd,
		.ex_result,
		.wb_rd,
		.wb_data,
		.op        ( dec_op    ),
		.opa       ( dec_opa   ),
		.opb       ( dec_opb   ),
		.rd        ( dec_rd    )
	);

	// ID/EX, held while execute stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_op <= ALU_NOP;
			ex_rd <= '0;
		end else if (!stall_req) begin
			ex_op <= dec_op;
			ex_rd <= dec_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_req) begin
			ex_opa <= dec_opa;
			ex_opb <= dec_opb;
		end
	end

	instr_exec i_exec(
		.clk,
		.rst,
		.op        ( ex_op     ),
		.opa       ( ex_opa    ),
		.opb       ( ex_opb    ),
		.result    ( ex_result ),
		.stall_req
	);

	// EX/WB takes a bubble during a stall
	always_ff @(posedge clk) begin
		if (rst || stall_req)
			wb_rd <= '0;
		else
			wb_rd <= ex_rd;
	end

	always_ff @(posedge clk) begin
		wb_data <= ex_result;
	end

	assign wb_valid = (wb_rd != '0);

endmodule

/* tests/tb_program.svh */
// program table, one entry per instruction
// columns: instruction word, expected destination (0 means no trace entry), expected value
localparam int PROG_LEN = 22;

localparam logic [68:0] PROG_TABLE [PROG_LEN] = '{
	// constants from r0: ori r1, lui r2, addiu r3 = -2, ori r2 with itself
	{32'h3401_1234, 5'd1,  32'h0000_1234},
	{32'h3c02_8765, 5'd2,  32'h8765_0000},
	{32'h2403_fffe, 5'd3,  32'hffff_fffe},
	{32'h3442_4321, 5'd2,  32'h8765_4321},
	// dependent chain: addu r4, subu r5, and r6, or r7, xor r8, slt r9, slt r10
	{32'h0041_2021, 5'd4,  32'h8765_5555},
	{32'h0083_2823, 5'd5,  32'h8765_5557},
	{32'h00a2_3024, 5'd6,  32'h8765_4101},
	{32'h00c3_3825, 5'd7,  32'hffff_ffff},
	{32'h00e1_4026, 5'd8,  32'hffff_edcb},
	{32'h0061_482a, 5'd9,  32'h0000_0001},
	{32'h0023_502a, 5'd10, 32'h0000_0000},
	// addu into r0, then addu r11 = r0 + r1
	{32'h0021_0021, 5'd0,  32'h0000_0000},
	{32'h0001_5821, 5'd11, 32'h0000_1234},
	// multu r2, r3 then mfhi r12, mflo r13, addu r14 = r12 + r13
	{32'h0043_0019, 5'd0,  32'h0000_0000},
	{32'h0000_6010, 5'd12, 32'h8765_431f},
	{32'h0000_6812, 5'd13, 32'hf135_79be},
	{32'h018d_7021, 5'd14, 32'h789a_bcdd},
	// multu r1, r1 then mflo r15, mfhi r16
	{32'h0021_0019, 5'd0,  32'h0000_0000},
	{32'h0000_7812, 5'd15, 32'h014b_5a90},
	{32'h0000_8010, 5'd16, 32'h0000_0000},
	// unknown opcode, then or r17 = r15 | r11
	{32'hfc00_0000, 5'd0,  32'h0000_0000},
	{32'h01eb_8825, 5'd17, 32'h014b_5ab4}
};

/* tests/cpu_core_tb.sv */
`timescale 1ns/10ps

module cpu_core_tb;
	import cpu_defs_pkg::*;
	import isa_pkg::*;

	`include "tb_program.svh"

	localparam int CYCLE_LIMIT  = 10 + PROG_LEN * (MUL_CYCLES + 3 + 3) + 50;
	localparam int DRAIN_CYCLES = 8;

	logic      clk;
	logic      rst;
	logic      instr_valid;
	instr_t    instr;
	logic      instr_ready;
	logic      wb_valid;
	reg_addr_t wb_rd;
	uint32_t   wb_data;

	reg_addr_t exp_rd [$];
	uint32_t   exp_data [$];
	int        chk_idx = 0;
	int        errors = 0;
	int        cycles = 0;
	int        stall_run = 0;

	cpu_core i_dut(.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// idle gap of 0 to 3 cycles, then hold the word until accepted
	task automatic send_instr(input instr_t word);
		int   gap;
		logic taken;
		gap = $urandom % 4;
		instr_valid = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b1;
		instr = word;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = instr_ready;
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b0;
	endtask

	// trace checker sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && wb_valid) begin
			if (chk_idx >= exp_rd.size()) begin
				errors++;
				$display("unexpected trace entry past the end of the list: rd %0d data %h",
					wb_rd, wb_data);
			end else begin
				assert (wb_rd == exp_rd[chk_idx]) else begin
					errors++;
					$display("[ERROR] wb_rd expected %h, got %h", exp_rd[chk_idx], wb_rd);
				end
				assert (wb_data == exp_data[chk_idx]) else begin
					errors++;
					$display("[ERROR] wb_data expected %h, got %h", exp_data[chk_idx], wb_data);
				end
				chk_idx++;
			end
		end
	end

	// each multiply holds instr_ready low for MUL_CYCLES-1 cycles
	always @(negedge clk) begin
		if (!rst) begin
			if (!instr_ready) begin
				stall_run++;
			end else if (stall_run != 0) begin
				assert (stall_run == MUL_CYCLES - 1) else begin
					errors++;
					$display("[ERROR] instr_ready low cycles expected %h, got %h",
						MUL_CYCLES - 1, stall_run);
				end
				stall_run = 0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d of %0d trace entries seen",
				cycles, chk_idx, exp_rd.size());
			$display("errors: %0d", errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hb5ae_ef71));
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			if (PROG_TABLE[i][36:32] != '0) begin
				exp_rd.push_back(PROG_TABLE[i][36:32]);
				exp_data.push_back(PROG_TABLE[i][31:0]);
			end
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < PROG_LEN; i++) begin
			send_instr(PROG_TABLE[i][68:37]);
		end
		while (chk_idx < exp_rd.size()) @(negedge clk);
		// stray entries after the last expected one
		repeat (DRAIN_CYCLES) @(negedge clk);
		$display("errors: %0d, trace entries checked: %0d", errors, chk_idx);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+tests
design/cpu_defs_pkg.sv
design/isa_pkg.sv
design/regfile.sv
design/decode.sv
design/instr_exec.sv
design/cpu_core.sv
tests/cpu_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f vlog.f --top-module cpu_core_tb -o cpu_core_sim &&
	./obj_dir/cpu_core_sim | tee /dev/stderr | grep -q "Simulation passed" ||
	{ echo "run did not pass"; exit 1; }
